// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ex_top
FLIST     := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/alu_arith.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_arith import ex_pkg::*; (
    input  alu_op_t op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   res_o,
    output logic    ovf_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic       is_sub;
    word_t      b_mux;
    word_t      sum;
    logic       lt_signed;
    logic       lt_unsigned;
    logic [5:0] n_zeros;
    logic [5:0] n_ones;

    // highest set bit wins, 32 when none
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i <= MSB; i++)
        begin
            if (v[i])
                n = 6'(MSB - i);
        end
        return n;
    endfunction

    assign is_sub = op_i inside {`EX_OP_SUB, `EX_OP_SUBU, `EX_OP_SLT};
    assign b_mux  = is_sub ? (~b_i + 1'b1) : b_i;
    assign sum    = a_i + b_mux;

    // operands of like sign, result sign flipped
    assign ovf_o = (a_i[MSB] == (b_i[MSB] ^ is_sub)) && (sum[MSB] != a_i[MSB]);

    assign lt_signed   = (a_i[MSB] && !b_i[MSB]) ||
                         ((a_i[MSB] == b_i[MSB]) && sum[MSB]);
    assign lt_unsigned = a_i < b_i;

    assign n_zeros = lead_zeros(a_i);
    assign n_ones  = lead_zeros(~a_i);

    always_comb
    begin
        case (op_i)
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU: res_o = sum;
            `EX_OP_SLT:  res_o = word_t'(lt_signed);
            `EX_OP_SLTU: res_o = word_t'(lt_unsigned);
            `EX_OP_CLZ:  res_o = word_t'(n_zeros);
            `EX_OP_CLO:  res_o = word_t'(n_ones);
            default:     res_o = '0;
        endcase
    end

endmodule

// File: hw/alu_logic_shift.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_logic_shift import ex_pkg::*; (
    input  alu_op_t op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   res_o
);

    logic [4:0] shamt;

    assign shamt = a_i[4:0];  // shift count from reg1

    always_comb
    begin
        case (op_i)
            `EX_OP_AND:
            begin
                res_o = a_i & b_i;
            end
            `EX_OP_OR:
            begin
                res_o = a_i | b_i;
            end
            `EX_OP_XOR:
            begin
                res_o = a_i ^ b_i;
            end
            `EX_OP_NOR:
            begin
                res_o = ~(a_i | b_i);
            end
            `EX_OP_SLL:
            begin
                res_o = b_i << shamt;
            end
            `EX_OP_SRL:
            begin
                res_o = b_i >> shamt;
            end
            `EX_OP_SRA:
            begin
                res_o = word_t'($signed(b_i) >>> shamt);  // sign fill
            end
            default:
            begin
                res_o = '0;
            end
        endcase
    end

endmodule

// File: hw/ex_ctrl.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_ctrl import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       valid_i,
    input  ex_req_t    req_i,
    input  word_t      logic_res_i,
    input  word_t      arith_res_i,
    input  logic       ovf_i,
    input  dword_t     prod_i,
    input  hilo_t      hilo_i,
    output logic       mul_signed_o,
    output logic       mul_load_o,
    output logic       hilo_we_o,
    output logic [1:0] hilo_src_o,
    output word_t      hilo_data_o,
    output alu_op_t    op_o,
    output word_t      opa_o,
    output word_t      opb_o,
    output logic       valid_o,
    output ex_res_t    res_o,
    output logic       busy_o
);

    mac_state_e state_q;
    mac_state_e state_d;
    alu_op_t    acc_op_q;
    reg_addr_t  acc_wd_q;
    logic       acc_wreg_q;
    logic       is_mac;
    logic       fire;      // single-cycle op accepted
    logic       ovf_kill;
    word_t      wdata;
    ex_res_t    res_d;

    assign op_o        = req_i.op;
    assign opa_o       = req_i.reg1;
    assign opb_o       = req_i.reg2;
    assign hilo_data_o = req_i.reg1;  // mthi/mtlo source

    assign is_mac = req_i.op inside {`EX_OP_MADD, `EX_OP_MADDU, `EX_OP_MSUB, `EX_OP_MSUBU};
    assign mul_signed_o = req_i.op inside {`EX_OP_MUL, `EX_OP_MULT, `EX_OP_MADD, `EX_OP_MSUB};
    assign mul_load_o = valid_i && (state_q == MAC_IDLE) && is_mac;
    assign fire = valid_i && (state_q == MAC_IDLE) && !is_mac;
    assign ovf_kill = (req_i.op inside {`EX_OP_ADD, `EX_OP_SUB}) && ovf_i;
    assign busy_o = (state_q == MAC_ACC);

    always_comb
    begin
        hilo_we_o  = 1'b0;
        hilo_src_o = `EX_HILO_MOVE;
        if (state_q == MAC_ACC)
        begin
            hilo_we_o  = 1'b1;
            hilo_src_o = (acc_op_q inside {`EX_OP_MSUB, `EX_OP_MSUBU}) ?
                         `EX_HILO_ACC_SUB : `EX_HILO_ACC_ADD;
        end
        else if (fire)
        begin
            case (req_i.op)
                `EX_OP_MTHI, `EX_OP_MTLO:
                begin
                    hilo_we_o = 1'b1;
                end
                `EX_OP_MULT, `EX_OP_MULTU:
                begin
                    hilo_we_o  = 1'b1;
                    hilo_src_o = `EX_HILO_LOAD;
                end
                default:
                begin
                end
            endcase
        end
    end

    // result class from opcode
    always_comb
    begin
        case (req_i.op)
            `EX_OP_AND, `EX_OP_OR, `EX_OP_XOR, `EX_OP_NOR,
            `EX_OP_SLL, `EX_OP_SRL, `EX_OP_SRA:                wdata = logic_res_i;
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU,
            `EX_OP_SLT, `EX_OP_SLTU, `EX_OP_CLZ, `EX_OP_CLO:   wdata = arith_res_i;
            `EX_OP_MUL:                                        wdata = prod_i[`EX_WORD_W-1:0];
            `EX_OP_MFHI:                                       wdata = hilo_i.hi;
            `EX_OP_MFLO:                                       wdata = hilo_i.lo;
            default:                                           wdata = '0;
        endcase
    end

    always_comb
    begin
        if (state_q == MAC_ACC)
            res_d = '{wd: acc_wd_q, wreg: acc_wreg_q, wdata: '0};
        else
            res_d = '{wd: req_i.wd, wreg: req_i.wreg && !ovf_kill, wdata: wdata};
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            MAC_IDLE: if (mul_load_o) state_d = MAC_ACC;
            MAC_ACC:  state_d = MAC_IDLE;  // product is ready, one cycle only
            default:  state_d = MAC_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            state_q <= MAC_IDLE;
            valid_o <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            valid_o <= fire || (state_q == MAC_ACC);
        end
    end

    always_ff @(posedge clk)
    begin
        if (mul_load_o)
        begin
            acc_op_q   <= req_i.op;
            acc_wd_q   <= req_i.wd;
            acc_wreg_q <= req_i.wreg;
        end
        if (fire || (state_q == MAC_ACC))
            res_o <= res_d;
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset_i)
        busy_o |-> !valid_i);
    a_busy_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        $rose(busy_o) |=> !busy_o && valid_o);

endmodule

// File: hw/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    // data word
    typedef logic [`EX_WORD_W-1:0] word_t;

    // full product or hi/lo pair
    typedef logic [2*`EX_WORD_W-1:0] dword_t;

    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`EX_OP_W-1:0] alu_op_t;

    // request from the issue side
    typedef struct packed {
        alu_op_t   op;
        word_t     reg1;   // also shift amount in [4:0]
        word_t     reg2;   // shifted value, or immediate
        reg_addr_t wd;
        logic      wreg;
    } ex_req_t;

    // register file write toward the next stage
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_res_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    // madd/msub group takes a second cycle
    typedef enum logic {
        MAC_IDLE = 1'b0,
        MAC_ACC  = 1'b1
    } mac_state_e;

endpackage

// File: hw/ex_top.sv
`timescale 1ns/1ps

module ex_top import ex_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    valid_i,
    input  ex_req_t req_i,
    output logic    valid_o,
    output ex_res_t res_o,
    output logic    busy_o
);

    word_t      logic_res;
    word_t      arith_res;
    logic       ovf;
    dword_t     prod;
    dword_t     prod_q;
    hilo_t      hilo;
    logic       mul_signed;
    logic       mul_load;
    logic       hilo_we;
    logic [1:0] hilo_src;
    word_t      hilo_data;
    alu_op_t    op;
    word_t      opa;
    word_t      opb;

    ex_ctrl u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .req_i        (req_i),
        .logic_res_i  (logic_res),
        .arith_res_i  (arith_res),
        .ovf_i        (ovf),
        .prod_i       (prod),
        .hilo_i       (hilo),
        .mul_signed_o (mul_signed),
        .mul_load_o   (mul_load),
        .hilo_we_o    (hilo_we),
        .hilo_src_o   (hilo_src),
        .hilo_data_o  (hilo_data),
        .op_o         (op),
        .opa_o        (opa),
        .opb_o        (opb),
        .valid_o      (valid_o),
        .res_o        (res_o),
        .busy_o       (busy_o)
    );

    alu_logic_shift u_logic (
        .op_i  (op),
        .a_i   (opa),
        .b_i   (opb),
        .res_o (logic_res)
    );

    alu_arith u_arith (
        .op_i  (op),
        .a_i   (opa),
        .b_i   (opb),
        .res_o (arith_res),
        .ovf_o (ovf)
    );

    mul_unit u_mul (
        .clk      (clk),
        .reset_i  (reset_i),
        .a_i      (opa),
        .b_i      (opb),
        .signed_i (mul_signed),
        .load_i   (mul_load),
        .prod_o   (prod),
        .prod_q_o (prod_q)
    );

    hilo_unit u_hilo (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (hilo_we),
        .src_i    (hilo_src),
        .data_i   (hilo_data),
        .op_i     (op),
        .prod_i   (prod),
        .prod_q_i (prod_q),
        .hilo_o   (hilo)
    );

endmodule

// File: hw/hilo_unit.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module hilo_unit import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       we_i,
    input  logic [1:0] src_i,
    input  word_t      data_i,
    input  alu_op_t    op_i,
    input  dword_t     prod_i,
    input  dword_t     prod_q_i,
    output hilo_t      hilo_o
);

    hilo_t  hilo_q;
    dword_t acc_sum;
    dword_t acc_diff;

    assign acc_sum  = dword_t'(hilo_q) + prod_q_i;
    assign acc_diff = dword_t'(hilo_q) - prod_q_i;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            hilo_q <= '0;
        end
        else if (we_i)
        begin
            case (src_i)
                `EX_HILO_MOVE:
                begin
                    if (op_i == `EX_OP_MTHI)
                        hilo_q.hi <= data_i;
                    else if (op_i == `EX_OP_MTLO)
                        hilo_q.lo <= data_i;
                end
                `EX_HILO_LOAD:    hilo_q <= hilo_t'(prod_i);  // mult, multu
                `EX_HILO_ACC_ADD: hilo_q <= hilo_t'(acc_sum);
                `EX_HILO_ACC_SUB: hilo_q <= hilo_t'(acc_diff);
                default:
                begin
                end
            endcase
        end
    end

    assign hilo_o = hilo_q;

    // accumulate only right after the product was captured
    a_acc_after_load: assert property (@(posedge clk) disable iff (reset_i)
        (we_i && (src_i inside {`EX_HILO_ACC_ADD, `EX_HILO_ACC_SUB})) |->
        ($past(op_i) inside {`EX_OP_MADD, `EX_OP_MADDU, `EX_OP_MSUB, `EX_OP_MSUBU})
        && (prod_q_i == $past(prod_i)));

endmodule

// File: hw/mul_unit.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module mul_unit import ex_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  word_t  a_i,
    input  word_t  b_i,
    input  logic   signed_i,
    input  logic   load_i,
    output dword_t prod_o,
    output dword_t prod_q_o
);

    localparam int MSB = `EX_WORD_W - 1;

    word_t  mag_a;
    word_t  mag_b;
    dword_t mag_p;
    logic   neg;

    // magnitudes for the signed forms
    assign mag_a = (signed_i && a_i[MSB]) ? (~a_i + 1'b1) : a_i;
    assign mag_b = (signed_i && b_i[MSB]) ? (~b_i + 1'b1) : b_i;

    assign mag_p = dword_t'(mag_a) * dword_t'(mag_b);
    assign neg   = signed_i && (a_i[MSB] ^ b_i[MSB]);

    assign prod_o = neg ? (~mag_p + 1'b1) : mag_p;

    // held for the accumulate cycle
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            prod_q_o <= '0;
        end
        else if (load_i)
        begin
            prod_q_o <= prod_o;
        end
    end

endmodule

// File: include/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define EX_WORD_W       32
`define EX_REG_ADDR_W   5
`define EX_OP_W         8

// opcodes, 8'h00 stays free for nop
`define EX_OP_AND       8'b0010_0100
`define EX_OP_OR        8'b0010_0101
`define EX_OP_XOR       8'b0010_0110
`define EX_OP_NOR       8'b0010_0111
`define EX_OP_SLL       8'b0111_1100
`define EX_OP_SRL       8'b0000_0010
`define EX_OP_SRA       8'b0000_0011
`define EX_OP_ADD       8'b0010_0000
`define EX_OP_ADDU      8'b0010_0001
`define EX_OP_SUB       8'b0010_0010
`define EX_OP_SUBU      8'b0010_0011
`define EX_OP_SLT       8'b0010_1010
`define EX_OP_SLTU      8'b0010_1011
`define EX_OP_CLZ       8'b1011_0000
`define EX_OP_CLO       8'b1011_0001
`define EX_OP_MUL       8'b1010_1001
`define EX_OP_MULT      8'b0001_1000
`define EX_OP_MULTU     8'b0001_1001
`define EX_OP_MADD      8'b1010_0110
`define EX_OP_MADDU     8'b1010_1000
`define EX_OP_MSUB      8'b1010_1010
`define EX_OP_MSUBU     8'b1010_1011
`define EX_OP_MFHI      8'b0001_0000
`define EX_OP_MTHI      8'b0001_0001
`define EX_OP_MFLO      8'b0001_0010
`define EX_OP_MTLO      8'b0001_0011

// hi/lo write source
`define EX_HILO_MOVE    2'd0
`define EX_HILO_LOAD    2'd1
`define EX_HILO_ACC_ADD 2'd2
`define EX_HILO_ACC_SUB 2'd3

`endif

// File: tb.f
+incdir+include
hw/ex_pkg.sv
hw/alu_logic_shift.sv
hw/alu_arith.sv
hw/mul_unit.sv
hw/hilo_unit.sv
hw/ex_ctrl.sv
hw/ex_top.sv
test/tb_ex_top.sv

// File: test/tb_ex_top.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_top import ex_pkg::*; ();

    localparam int MAX_WAIT = 20;  // cycles before a wait gives up

    logic    clk;
    logic    reset_i;
    logic    valid_i;
    ex_req_t req_i;
    logic    valid_o;
    ex_res_t res_o;
    logic    busy_o;

    integer seed = 32'he344;
    int     errors = 0;
    int     checks = 0;

    ex_top u_dut (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .res_o   (res_o),
        .busy_o  (busy_o)
    );

    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_res(input string name, input ex_res_t got, input ex_res_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_hilo(input string name, input hilo_t got, input hilo_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic ex_req_t make_req(alu_op_t op, word_t a, word_t b, reg_addr_t wd,
                                         logic wreg);
        return '{op: op, reg1: a, reg2: b, wd: wd, wreg: wreg};
    endfunction

    function automatic word_t expect_logic(alu_op_t op, word_t a, word_t b);
        logic [4:0] s;
        s = a[4:0];
        case (op)
            `EX_OP_AND: return a & b;
            `EX_OP_OR:  return a | b;
            `EX_OP_XOR: return a ^ b;
            `EX_OP_NOR: return ~(a | b);
            `EX_OP_SLL: return b << s;
            `EX_OP_SRL: return b >> s;
            `EX_OP_SRA: return (b >> s) | ({32{b[31]}} & ~(32'hffff_ffff >> s));
            default:    return '0;
        endcase
    endfunction

    function automatic word_t expect_arith(alu_op_t op, word_t a, word_t b);
        case (op)
            `EX_OP_ADD, `EX_OP_ADDU: return a + b;
            `EX_OP_SUB, `EX_OP_SUBU: return a - b;
            `EX_OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `EX_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:     return '0;
        endcase
    endfunction

    // true result outside the 32-bit signed range
    function automatic logic signed_overflow(alu_op_t op, word_t a, word_t b);
        longint sa;
        longint sb;
        longint s;
        sa = $signed(a);
        sb = $signed(b);
        if (op == `EX_OP_ADD)
            s = sa + sb;
        else if (op == `EX_OP_SUB)
            s = sa - sb;
        else
            return 1'b0;
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    function automatic word_t lead_count(word_t v, logic bit_val);
        int  n;
        logic done;
        n = 0;
        done = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!done && v[i] == bit_val)
                n++;
            else
                done = 1'b1;
        end
        return word_t'(n);
    endfunction

    function automatic dword_t full_product(word_t a, word_t b, logic sgn);
        dword_t x;
        dword_t y;
        x = sgn ? {{32{a[31]}}, a} : {32'd0, a};
        y = sgn ? {{32{b[31]}}, b} : {32'd0, b};
        return x * y;  // mod 2^64 is the exact signed product
    endfunction

    // one strobe, then wait for valid_o
    task automatic run_op(input ex_req_t req, output ex_res_t res, output int lat,
                          output int busy_n);
        logic got;
        got = 1'b0;
        lat = 0;
        busy_n = 0;
        req_i = req;
        valid_i = 1'b1;
        for (int i = 0; i < MAX_WAIT && !got; i++)
        begin
            @(posedge clk);
            #1;
            valid_i = 1'b0;
            lat++;
            if (busy_o)
                busy_n++;
            if (valid_o)
                got = 1'b1;
        end
        if (!got)
        begin
            errors++;
            $display("timeout at %0t: no valid_o for op %h", $time, req.op);
        end
        res = res_o;
    endtask

    task automatic read_hilo(output hilo_t h);
        ex_res_t r;
        int      lat;
        int      bn;
        run_op(make_req(`EX_OP_MFHI, '0, '0, 5'd2, 1'b1), r, lat, bn);
        h.hi = r.wdata;
        run_op(make_req(`EX_OP_MFLO, '0, '0, 5'd3, 1'b1), r, lat, bn);
        h.lo = r.wdata;
    endtask

    task automatic set_hilo(input hilo_t h);
        ex_res_t r;
        int      lat;
        int      bn;
        run_op(make_req(`EX_OP_MTHI, h.hi, '0, '0, 1'b0), r, lat, bn);
        run_op(make_req(`EX_OP_MTLO, h.lo, '0, '0, 1'b0), r, lat, bn);
    endtask

    task automatic reset_state();
        hilo_t h;
        check_word("valid_o after reset", word_t'(valid_o), '0);
        check_word("busy_o after reset", word_t'(busy_o), '0);
        read_hilo(h);
        check_hilo("hilo after reset", h, '0);
    endtask

    task automatic logic_shift_ops();
        alu_op_t   ops [7];
        word_t     a;
        word_t     b;
        reg_addr_t wd;
        ex_res_t   r;
        int        lat;
        int        bn;
        ops = '{`EX_OP_AND, `EX_OP_OR, `EX_OP_XOR, `EX_OP_NOR,
                `EX_OP_SLL, `EX_OP_SRL, `EX_OP_SRA};
        foreach (ops[k])
        begin
            for (int i = 0; i < 4; i++)
            begin
                a = $random(seed);
                b = $random(seed);
                if (i[0])
                    b[31] = 1'b1;  // negative value for sra
                wd = reg_addr_t'($random(seed));
                run_op(make_req(ops[k], a, b, wd, i[1]), r, lat, bn);
                check_res("logic/shift result", r, '{wd: wd, wreg: i[1],
                          wdata: expect_logic(ops[k], a, b)});
            end
        end
    endtask

    task automatic add_sub_compare();
        alu_op_t   ops [6];
        word_t     xa [8];
        word_t     xb [8];
        reg_addr_t wd;
        ex_res_t   r;
        int        lat;
        int        bn;
        ops = '{`EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU, `EX_OP_SLT, `EX_OP_SLTU};
        xa[0] = 32'h7fff_ffff;
        xb[0] = 32'h0000_0001;
        xa[1] = 32'h8000_0000;
        xb[1] = 32'h0000_0001;
        xa[2] = 32'h8000_0000;
        xb[2] = 32'hffff_ffff;
        xa[3] = 32'hffff_ffff;
        xb[3] = 32'h0000_0001;
        for (int i = 4; i < 8; i++)
        begin
            xa[i] = $random(seed);
            xb[i] = $random(seed);
        end
        foreach (ops[k])
        begin
            for (int i = 0; i < 8; i++)
            begin
                wd = reg_addr_t'(i + 8);
                run_op(make_req(ops[k], xa[i], xb[i], wd, 1'b1), r, lat, bn);
                check_res("arith result", r, '{wd: wd,
                          wreg: !signed_overflow(ops[k], xa[i], xb[i]),
                          wdata: expect_arith(ops[k], xa[i], xb[i])});
            end
        end
    endtask

    task automatic lead_count_ops();
        word_t   v [4];
        int      pos;
        ex_res_t r;
        int      lat;
        int      bn;
        pos = $unsigned($random(seed)) % 32;
        v = '{32'h0, 32'hffff_ffff, 32'h1 << pos, ~(32'h1 << pos)};
        foreach (v[i])
        begin
            run_op(make_req(`EX_OP_CLZ, v[i], '0, 5'd4, 1'b1), r, lat, bn);
            check_word("clz", r.wdata, lead_count(v[i], 1'b0));
            run_op(make_req(`EX_OP_CLO, v[i], '0, 5'd5, 1'b1), r, lat, bn);
            check_word("clo", r.wdata, lead_count(v[i], 1'b1));
        end
    endtask

    task automatic multiply_ops();
        word_t   a;
        word_t   b;
        hilo_t   h;
        hilo_t   exp;
        ex_res_t r;
        int      lat;
        int      bn;
        a = $random(seed);
        b = $random(seed) | 32'h8000_0000;
        run_op(make_req(`EX_OP_MUL, a, b, 5'd6, 1'b1), r, lat, bn);
        check_word("mul low word", r.wdata, word_t'(full_product(a, b, 1'b1)));
        run_op(make_req(`EX_OP_MULT, a, b, '0, 1'b0), r, lat, bn);
        read_hilo(h);
        check_hilo("hilo after mult", h, hilo_t'(full_product(a, b, 1'b1)));
        run_op(make_req(`EX_OP_MULTU, a, b, '0, 1'b0), r, lat, bn);
        read_hilo(h);
        check_hilo("hilo after multu", h, hilo_t'(full_product(a, b, 1'b0)));
        exp = h;
        exp.hi = $random(seed);
        run_op(make_req(`EX_OP_MTHI, exp.hi, '0, '0, 1'b0), r, lat, bn);
        read_hilo(h);
        check_hilo("hilo after mthi", h, exp);
        exp.lo = $random(seed);
        run_op(make_req(`EX_OP_MTLO, exp.lo, '0, '0, 1'b0), r, lat, bn);
        read_hilo(h);
        check_hilo("hilo after mtlo", h, exp);
    endtask

    task automatic accumulate_ops();
        alu_op_t ops [4];
        logic    sgn;
        word_t   a;
        word_t   b;
        hilo_t   old;
        hilo_t   h;
        dword_t  p;
        ex_res_t r;
        int      lat;
        int      bn;
        ops = '{`EX_OP_MADD, `EX_OP_MADDU, `EX_OP_MSUB, `EX_OP_MSUBU};
        foreach (ops[k])
        begin
            old.hi = $random(seed);
            old.lo = $random(seed);
            set_hilo(old);
            a = $random(seed);
            b = $random(seed);
            sgn = ops[k] inside {`EX_OP_MADD, `EX_OP_MSUB};
            p = full_product(a, b, sgn);
            run_op(make_req(ops[k], a, b, 5'd7, 1'b0), r, lat, bn);
            check_word("mac latency", word_t'(lat), 32'd2);
            check_word("mac busy cycles", word_t'(bn), 32'd1);
            read_hilo(h);
            if (ops[k] inside {`EX_OP_MADD, `EX_OP_MADDU})
                check_hilo("hilo after madd", h, hilo_t'(dword_t'(old) + p));
            else
                check_hilo("hilo after msub", h, hilo_t'(dword_t'(old) - p));
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset_i = 1'b1;
        valid_i = 1'b0;
        req_i = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;
        reset_state();
        logic_shift_ops();
        add_sub_compare();
        lead_count_ops();
        multiply_ops();
        accumulate_ops();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
